/* hdl/core_cfg_pkg.sv */
//////////////////////////////
// bridge map and controller types for the core control plane
// bridge data is big-endian, no byte lanes
//////////////////////////////
`default_nettype none

package core_cfg_pkg;

    typedef logic [31:0] bridge_word_t;

    // settings write addresses, readback shares the same space
    localparam bridge_word_t ADDR_TURBO       = 32'h00C0_0000;
    localparam bridge_word_t ADDR_FM_CHIP     = 32'h00A0_0000;
    localparam bridge_word_t ADDR_FILTER      = 32'h00F0_0000;
    localparam bridge_word_t ADDR_MULTITAP    = 32'h0000_0000;
    localparam bridge_word_t ADDR_AR          = 32'h0000_0010;
    localparam bridge_word_t ADDR_COMPOSITE   = 32'h0000_0020; // bit 1 is auto composite
    localparam bridge_word_t ADDR_OBJ_LIMIT   = 32'h0000_0030;
    localparam bridge_word_t ADDR_FM          = 32'h0000_0040;
    localparam bridge_word_t ADDR_PSG         = 32'h0000_0050;
    localparam bridge_word_t ADDR_HIFI_PCM    = 32'h0000_0060;
    localparam bridge_word_t ADDR_RESET_DELAY = 32'h0000_0070; // any nonzero value
    localparam bridge_word_t ADDR_M30         = 32'h0000_0080;
    localparam bridge_word_t ADDR_MENU_PAUSE  = 32'h0000_0090;
    localparam bridge_word_t ADDR_REGION      = 32'h00E0_0000; // read only

    typedef struct packed {
        logic [1:0] cpu_turbo;
        logic       multitap;
        logic       menu_pause;
        logic       obj_limit_high;
        logic       ar_correction;
        logic       composite;
        logic       auto_composite;
        logic       fm_enable;
        logic       psg_enable;
        logic       hifi_pcm;
        logic [1:0] audio_filter;
        logic       fm_chip;
        logic       m30_map;
    } core_settings_t;

    localparam core_settings_t SETTINGS_RESET = '{
        obj_limit_high: 1'b1,
        fm_enable:      1'b1,
        psg_enable:     1'b1,
        hifi_pcm:       1'b1,
        default:        '0
    };

    // controller key bitmap, dpad_up is bit 0
    typedef struct packed {
        logic face_start;
        logic face_select;
        logic trig_r3;
        logic trig_l3;
        logic trig_r2;
        logic trig_l2;
        logic trig_r1;
        logic trig_l1;
        logic face_y;
        logic face_x;
        logic face_b;
        logic face_a;
        logic dpad_right;
        logic dpad_left;
        logic dpad_down;
        logic dpad_up;
    } pocket_keys_t;

    typedef struct packed {
        logic z;
        logic y;
        logic x;
        logic mode;
        logic start;
        logic b;
        logic c;
        logic a;
        logic up;
        logic down;
        logic left;
        logic right;
    } genesis_pad_t;

    localparam int NUM_PADS = 4;

endpackage

`default_nettype wire

/* hdl/cart_pkg.sv */
//////////////////////////////
// cartridge header layout and per-title quirks
// offsets are byte addresses inside the ROM download space
//////////////////////////////
`default_nettype none

package cart_pkg;

    localparam logic [3:0] ROM_SPACE = 4'h1; // bridge_addr[31:28] of ROM writes

    // header words, 32-bit aligned
    localparam logic [27:0] HDR_ID_BASE = 28'h180; // first ID byte at 'h183
    localparam logic [27:0] HDR_ID_DONE = 28'h18C;
    localparam logic [27:0] HDR_REGION  = 28'h1F0;
    localparam logic [27:0] HDR_READY   = 28'h200;

    typedef logic [63:0] title_id_t; // 8 ascii chars, first char in the top byte

    typedef enum logic [1:0] {
        REGION_JP = 2'd0,
        REGION_US = 2'd1,
        REGION_EU = 2'd2
    } region_t;

    typedef struct packed {
        logic sram;
        logic sram00;
        logic eeprom;
        logic noram;
        logic fifo;
        logic svp;
        logic fmbusy;
    } cart_quirks_t;

    ////////////////////////////// title table

    localparam title_id_t ID_NFL_QBC       = "T-081276";
    localparam title_id_t ID_NBA_JAM_TE    = "T-81406 ";
    localparam title_id_t ID_HOLYFIELD     = "MK-1215 ";
    localparam title_id_t ID_WONDER_BOY    = "G-4060  ";
    localparam title_id_t ID_PUGGSY        = "T-113016"; // fake ram check
    localparam title_id_t ID_CLUE          = "T-89016 ";
    localparam title_id_t ID_VIRTUA_RACING = "MK-1229 ";
    localparam title_id_t ID_HELLFIRE      = "T-35036 ";
    localparam title_id_t ID_SONIC_REMAST  = " GM 0000";

endpackage

`default_nettype wire

/* hdl/core_settings.sv */
//////////////////////////////
// bridge settings registers, delayed core reset and pause
// core_reset is combinational from the delay counter and region_hold
// reset delay length depends on a free counter, so it is not fixed
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module core_settings (
    input  logic                          clk_74a,
    input  logic                          pll_core_locked,
    input  core_cfg_pkg::bridge_word_t    bridge_addr,
    input  logic                          bridge_wr,
    input  core_cfg_pkg::bridge_word_t    bridge_wr_data,
    input  logic                          bridge_rd,
    input  logic                          osnotify_inmenu,
    input  cart_pkg::region_t             region,
    input  logic                          region_hold,
    output core_cfg_pkg::core_settings_t  settings,
    output logic                          core_reset,
    output logic                          pause,
    output core_cfg_pkg::bridge_word_t    bridge_rd_data
);

    import core_cfg_pkg::*;

    logic [11:0] free_cnt;    // seeds the delay length
    logic [15:0] reset_delay;

    //////////////////////////////
    // register writes

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            settings    <= SETTINGS_RESET;
            free_cnt    <= '0;
            reset_delay <= '0;
            pause       <= 1'b0;
        end else begin
            free_cnt <= free_cnt + 1'b1;
            pause    <= settings.menu_pause && osnotify_inmenu;

            // hold the count while the host menu is up
            if (reset_delay != '0 && !osnotify_inmenu)
                reset_delay <= reset_delay - 1'b1;

            if (bridge_wr) begin
                case (bridge_addr)
                    ADDR_TURBO:      settings.cpu_turbo      <= bridge_wr_data[1:0];
                    ADDR_FM_CHIP:    settings.fm_chip        <= bridge_wr_data[0];
                    ADDR_FILTER:     settings.audio_filter   <= bridge_wr_data[1:0];
                    ADDR_MULTITAP:   settings.multitap       <= bridge_wr_data[0];
                    ADDR_AR:         settings.ar_correction  <= bridge_wr_data[0];
                    ADDR_COMPOSITE: begin
                        settings.composite      <= bridge_wr_data[0];
                        settings.auto_composite <= bridge_wr_data[1];
                    end
                    ADDR_OBJ_LIMIT:  settings.obj_limit_high <= bridge_wr_data[0];
                    ADDR_FM:         settings.fm_enable      <= bridge_wr_data[0];
                    ADDR_PSG:        settings.psg_enable     <= bridge_wr_data[0];
                    ADDR_HIFI_PCM:   settings.hifi_pcm       <= bridge_wr_data[0];
                    ADDR_RESET_DELAY: begin
                        if (bridge_wr_data != '0)
                            reset_delay <= {free_cnt, 4'b1111};
                    end
                    ADDR_M30:        settings.m30_map        <= bridge_wr_data[0];
                    ADDR_MENU_PAUSE: settings.menu_pause     <= bridge_wr_data[0];
                    default: ; // unmapped, ignored
                endcase
            end
        end
    end

    //////////////////////////////
    // read mux, one cycle latency

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            bridge_rd_data <= '0;
        end else if (bridge_rd) begin
            if (bridge_addr == ADDR_REGION)
                bridge_rd_data <= bridge_word_t'(region);
            else
                bridge_rd_data <= '0;
        end
    end

    assign core_reset = (reset_delay != '0) || region_hold;

    // the bridge issues one access at a time
    a_rd_wr_exclusive : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        !(bridge_rd && bridge_wr));

    // a nonzero delay write holds the core in reset
    a_delay_resets : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        bridge_wr && bridge_addr == ADDR_RESET_DELAY && bridge_wr_data != '0 |=> core_reset);

endmodule

`default_nettype wire

/* hdl/cart_header_parser.sv */
//////////////////////////////
// snoops ROM download words for region code and title ID
// expects each header word written once per download
// region stays from the last download until the next HDR_READY
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cart_header_parser (
    input  logic                        clk_74a,
    input  logic                        pll_core_locked,
    input  core_cfg_pkg::bridge_word_t  bridge_addr,
    input  logic                        bridge_wr,
    input  core_cfg_pkg::bridge_word_t  bridge_wr_data,
    input  logic                        dataslot_requestwrite,
    input  logic                        dataslot_allcomplete,
    output cart_pkg::region_t           region,
    output logic                        region_hold,
    output cart_pkg::cart_quirks_t      quirks
);

    import cart_pkg::*;

    logic        download;      // window open
    logic        rom_wr;
    logic [27:0] rom_addr;
    logic [2:0]  region_flags;  // {e, u, j}
    logic [2:0]  flags_next;
    logic [7:0]  byte0;
    logic [7:0]  byte1;
    logic [7:0]  byte2;
    logic [7:0]  digit;
    logic        is_hex;
    title_id_t   cart_id;

    assign rom_wr   = bridge_wr && download && (bridge_addr[31:28] == ROM_SPACE);
    assign rom_addr = bridge_addr[27:0];

    // big-endian, lowest byte address in the top lane
    assign byte0 = bridge_wr_data[31:24];
    assign byte1 = bridge_wr_data[23:16];
    assign byte2 = bridge_wr_data[15:8];

    function automatic logic [2:0] letter_flags(input logic [7:0] c);
        case (c)
            "J":     return 3'b001;
            "U":     return 3'b010;
            "E":     return 3'b100;
            default: return 3'b000;
        endcase
    endfunction

    function automatic region_t pick_region(input logic [2:0] f);
        if (f[1])      return REGION_US;
        else if (f[2]) return REGION_EU;
        else if (f[0]) return REGION_JP;
        else           return REGION_US; // nothing recognised
    endfunction

    function automatic cart_quirks_t quirk_lookup(input title_id_t id);
        cart_quirks_t q;
        q = '0;
        case (id)
            ID_NFL_QBC, ID_NBA_JAM_TE: q.sram   = 1'b1;
            ID_HOLYFIELD, ID_WONDER_BOY: q.eeprom = 1'b1;
            ID_PUGGSY:         q.noram  = 1'b1;
            ID_CLUE:           q.fifo   = 1'b1;
            ID_VIRTUA_RACING:  q.svp    = 1'b1;
            ID_HELLFIRE:       q.fmbusy = 1'b1;
            ID_SONIC_REMAST:   q.sram00 = 1'b1;
            default: ;
        endcase
        return q;
    endfunction

    //////////////////////////////
    // region byte decode

    assign is_hex = (byte0 >= "0" && byte0 <= "9") || (byte0 >= "A" && byte0 <= "F");
    assign digit  = (byte0 >= "A") ? byte0 - 8'd7 : byte0; // A-F down to 10-15

    always_comb begin
        // a hex digit in the first byte is a region bitmask
        if (is_hex)
            flags_next = {digit[3], digit[2], digit[0]};
        else
            flags_next = region_flags | letter_flags(byte0);
        flags_next = flags_next | letter_flags(byte1) | letter_flags(byte2);
    end

    //////////////////////////////
    // window, flags, quirks

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            download     <= 1'b0;
            region_flags <= '0;
            quirks       <= '0;
            region       <= REGION_JP;
            region_hold  <= 1'b0;
        end else begin
            if (dataslot_requestwrite) begin
                download     <= 1'b1;
                region_flags <= '0;
                quirks       <= '0;
            end else if (dataslot_allcomplete) begin
                download    <= 1'b0;
                region_hold <= 1'b0;
            end

            if (rom_wr) begin
                case (rom_addr)
                    HDR_REGION:  region_flags <= flags_next;
                    HDR_ID_DONE: quirks       <= quirk_lookup(cart_id);
                    HDR_READY: begin
                        region      <= pick_region(region_flags);
                        region_hold <= 1'b1; // core waits for the download to end
                    end
                    default: ;
                endcase
            end
        end
    end

    // ID bytes 'h183 to 'h18A
    always_ff @(posedge clk_74a) begin
        if (rom_wr) begin
            case (rom_addr)
                HDR_ID_BASE:         cart_id[63:56] <= bridge_wr_data[7:0];
                HDR_ID_BASE + 28'h4: cart_id[55:24] <= bridge_wr_data;
                HDR_ID_BASE + 28'h8: cart_id[23:0]  <= bridge_wr_data[31:8];
                default: ;
            endcase
        end
    end

    // table entries are exclusive
    a_one_quirk : assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        $onehot0(quirks));

endmodule

`default_nettype wire

/* hdl/pad_mapper.sv */
//////////////////////////////
// maps controller keys to six-button pads, one cycle late
// m30_map selects the alternate face button layout
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pad_mapper (
    input  logic                                                    clk_74a,
    input  logic                                                    pll_core_locked,
    input  core_cfg_pkg::pocket_keys_t [core_cfg_pkg::NUM_PADS-1:0] keys,
    input  logic                                                    m30_map,
    output core_cfg_pkg::genesis_pad_t [core_cfg_pkg::NUM_PADS-1:0] pads
);

    import core_cfg_pkg::*;

    function automatic genesis_pad_t map_pad(input pocket_keys_t k, input logic m30);
        genesis_pad_t p;
        p.up    = k.dpad_up;
        p.down  = k.dpad_down;
        p.left  = k.dpad_left;
        p.right = k.dpad_right;
        p.mode  = k.face_select;
        p.start = k.face_start;
        p.c     = k.face_b; // same in both layouts
        if (m30) begin
            p.a = k.face_a;
            p.b = k.trig_r2;
            p.x = k.face_x;
            p.y = k.face_y;
            p.z = k.trig_l2;
        end else begin
            p.a = k.face_y;  // bottom row on the right
            p.b = k.face_a;
            p.x = k.trig_l1;
            p.y = k.face_x;
            p.z = k.trig_r1;
        end
        return p;
    endfunction

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            pads <= '0;
        end else begin
            for (int i = 0; i < NUM_PADS; i++)
                pads[i] <= map_pad(keys[i], m30_map);
        end
    end

endmodule

`default_nettype wire

/* hdl/core_top.sv */
//////////////////////////////
// control plane top, everything on clk_74a
// bridge data taken as big-endian
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                                                    clk_74a,
    input  logic                                                    pll_core_locked,

    // bridge
    input  core_cfg_pkg::bridge_word_t                              bridge_addr,
    input  logic                                                    bridge_wr,
    input  core_cfg_pkg::bridge_word_t                              bridge_wr_data,
    input  logic                                                    bridge_rd,
    output core_cfg_pkg::bridge_word_t                              bridge_rd_data,

    // host notifications
    input  logic                                                    osnotify_inmenu,
    input  logic                                                    dataslot_requestwrite,
    input  logic                                                    dataslot_allcomplete,

    input  core_cfg_pkg::pocket_keys_t [core_cfg_pkg::NUM_PADS-1:0] keys,

    output core_cfg_pkg::core_settings_t                            settings,
    output core_cfg_pkg::genesis_pad_t [core_cfg_pkg::NUM_PADS-1:0] pads,
    output cart_pkg::cart_quirks_t                                  quirks,
    output cart_pkg::region_t                                       region,
    output logic                                                    core_reset,
    output logic                                                    pause
);

    logic region_hold; // header seen, download still running

    core_settings i_settings (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .bridge_addr     (bridge_addr),
        .bridge_wr       (bridge_wr),
        .bridge_wr_data  (bridge_wr_data),
        .bridge_rd       (bridge_rd),
        .osnotify_inmenu (osnotify_inmenu),
        .region          (region),
        .region_hold     (region_hold),
        .settings        (settings),
        .core_reset      (core_reset),
        .pause           (pause),
        .bridge_rd_data  (bridge_rd_data)
    );

    cart_header_parser i_parser (
        .clk_74a               (clk_74a),
        .pll_core_locked       (pll_core_locked),
        .bridge_addr           (bridge_addr),
        .bridge_wr             (bridge_wr),
        .bridge_wr_data        (bridge_wr_data),
        .dataslot_requestwrite (dataslot_requestwrite),
        .dataslot_allcomplete  (dataslot_allcomplete),
        .region                (region),
        .region_hold           (region_hold),
        .quirks                (quirks)
    );

    pad_mapper i_pads (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .keys            (keys),
        .m30_map         (settings.m30_map),
        .pads            (pads)
    );

endmodule

`default_nettype wire

/* tests/tb_model.svh */
//////////////////////////////
// reference model of the control plane outputs
// included inside tb_core_top after the package imports
//////////////////////////////
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// settings right after reset
function automatic core_settings_t reset_settings();
    core_settings_t s;
    s = '0;
    s.obj_limit_high = 1'b1;
    s.fm_enable      = 1'b1;
    s.psg_enable     = 1'b1;
    s.hifi_pcm       = 1'b1;
    return s;
endfunction

// one bridge write applied to the settings
function automatic core_settings_t next_settings(input core_settings_t s,
                                                 input bridge_word_t addr,
                                                 input bridge_word_t data);
    core_settings_t n;
    n = s;
    if (addr == ADDR_TURBO)           n.cpu_turbo      = data[1:0];
    else if (addr == ADDR_FM_CHIP)    n.fm_chip        = data[0];
    else if (addr == ADDR_FILTER)     n.audio_filter   = data[1:0];
    else if (addr == ADDR_MULTITAP)   n.multitap       = data[0];
    else if (addr == ADDR_AR)         n.ar_correction  = data[0];
    else if (addr == ADDR_COMPOSITE)  {n.auto_composite, n.composite} = data[1:0];
    else if (addr == ADDR_OBJ_LIMIT)  n.obj_limit_high = data[0];
    else if (addr == ADDR_FM)         n.fm_enable      = data[0];
    else if (addr == ADDR_PSG)        n.psg_enable     = data[0];
    else if (addr == ADDR_HIFI_PCM)   n.hifi_pcm       = data[0];
    else if (addr == ADDR_M30)        n.m30_map        = data[0];
    else if (addr == ADDR_MENU_PAUSE) n.menu_pause     = data[0];
    return n;
endfunction

// pad bits in order z y x mode start b c a up down left right
function automatic genesis_pad_t expected_pad(input pocket_keys_t k, input logic m30);
    logic [15:0] b;
    b = k;
    if (m30)
        return {b[10], b[7], b[6], b[14], b[15], b[11], b[5], b[4], b[0], b[1], b[2], b[3]};
    else
        return {b[9], b[6], b[8], b[14], b[15], b[4], b[5], b[7], b[0], b[1], b[2], b[3]};
endfunction

function automatic cart_quirks_t expected_quirks(input title_id_t id);
    cart_quirks_t q;
    q = '0;
    q.sram   = (id == "T-081276") || (id == "T-81406 ");
    q.eeprom = (id == "MK-1215 ") || (id == "G-4060  ");
    q.noram  = (id == "T-113016");
    q.fifo   = (id == "T-89016 ");
    q.svp    = (id == "MK-1229 ");
    q.fmbusy = (id == "T-35036 ");
    q.sram00 = (id == " GM 0000");
    return q;
endfunction

// bytes at 'h1F0, 'h1F1 and 'h1F2 of the header
function automatic region_t expected_region(input logic [7:0] b0, b1, b2);
    logic j;
    logic u;
    logic e;
    logic [7:0] v;
    j = (b0 == "J") || (b1 == "J") || (b2 == "J");
    u = (b0 == "U") || (b1 == "U") || (b2 == "U");
    e = (b0 == "E") || (b1 == "E") || (b2 == "E");
    if (b0 >= "0" && b0 <= "9")
        v = b0 - "0";
    else if (b0 >= "A" && b0 <= "F")
        v = b0 - "A" + 8'd10;
    else
        v = 8'd0; // not a digit, no mask
    j = j | v[0];
    u = u | v[2];
    e = e | v[3];
    if (u)
        return REGION_US;
    else if (e)
        return REGION_EU;
    else if (j)
        return REGION_JP;
    else
        return REGION_US;
endfunction

`endif

/* tests/tb_core_top.sv */
//////////////////////////////
// random testbench for core_top against tb_model.svh
// fixed seed, all checks at the falling edge
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

    import core_cfg_pkg::*;
    import cart_pkg::*;

    localparam int SETTINGS_WRITES = 200;
    localparam int KEY_ROUNDS      = 100;
    localparam int DOWNLOADS       = 40;
    localparam int DELAY_TIMEOUT   = 70000; // cycles, delay counter is 16 bits

    logic                        clk_74a;
    logic                        pll_core_locked;
    bridge_word_t                bridge_addr;
    logic                        bridge_wr;
    bridge_word_t                bridge_wr_data;
    logic                        bridge_rd;
    bridge_word_t                bridge_rd_data;
    logic                        osnotify_inmenu;
    logic                        dataslot_requestwrite;
    logic                        dataslot_allcomplete;
    pocket_keys_t [NUM_PADS-1:0] keys;
    core_settings_t              settings;
    genesis_pad_t [NUM_PADS-1:0] pads;
    cart_quirks_t                quirks;
    region_t                     region;
    logic                        core_reset;
    logic                        pause;

    core_settings_t exp_settings;
    int             errors;
    int             checks;

    // region readback address last
    bridge_word_t map_addrs [14] = '{ADDR_TURBO, ADDR_FM_CHIP, ADDR_FILTER, ADDR_MULTITAP,
        ADDR_AR, ADDR_COMPOSITE, ADDR_OBJ_LIMIT, ADDR_FM, ADDR_PSG, ADDR_HIFI_PCM,
        ADDR_RESET_DELAY, ADDR_M30, ADDR_MENU_PAUSE, ADDR_REGION};

    title_id_t titles [9] = '{"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", "T-113016",
        "T-89016 ", "MK-1229 ", "T-35036 ", " GM 0000"};

    `include "tb_model.svh"

    core_top i_dut (.*);

    initial clk_74a = 1'b0;
    always #50 clk_74a = ~clk_74a;

    task automatic compare_value(input logic [63:0] actual, input logic [63:0] expected,
                                 input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic write_bus(input bridge_word_t addr, input bridge_word_t data);
        @(posedge clk_74a);
        bridge_addr    <= addr;
        bridge_wr_data <= data;
        bridge_wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_wr <= 1'b0;
        @(negedge clk_74a);
    endtask

    task automatic read_bus(input bridge_word_t addr, output bridge_word_t data);
        @(posedge clk_74a);
        bridge_addr <= addr;
        bridge_rd   <= 1'b1;
        @(posedge clk_74a);
        bridge_rd <= 1'b0;
        @(negedge clk_74a);
        data = bridge_rd_data;
    endtask

    task automatic write_setting(input bridge_word_t addr, input bridge_word_t data);
        write_bus(addr, data);
        exp_settings = next_settings(exp_settings, addr, data);
        compare_value(64'(settings), 64'(exp_settings), "settings after write");
    endtask

    task automatic check_pads();
        for (int i = 0; i < NUM_PADS; i++)
            compare_value(64'(pads[i]), 64'(expected_pad(keys[i], exp_settings.m30_map)),
                          $sformatf("pad %0d", i));
    endtask

    function automatic bridge_word_t rom_word(input logic [27:0] offset);
        return {ROM_SPACE, offset};
    endfunction

    // letter, hex digit or any byte
    function automatic logic [7:0] random_region_byte();
        int v;
        v = $urandom_range(0, 15);
        case ($urandom_range(0, 2))
            0:       return (v < 5) ? "J" : ((v < 10) ? "U" : "E");
            1:       return (v < 10) ? 8'("0" + v) : 8'("A" + v - 10);
            default: return 8'($urandom);
        endcase
    endfunction

    task automatic open_download();
        @(posedge clk_74a);
        dataslot_requestwrite <= 1'b1;
        @(posedge clk_74a);
        dataslot_requestwrite <= 1'b0;
        @(negedge clk_74a);
        compare_value(64'(quirks), 64'd0, "quirks on a new download");
    endtask

    task automatic finish_download();
        @(posedge clk_74a);
        dataslot_allcomplete <= 1'b1;
        @(negedge clk_74a);
        compare_value(64'(core_reset), 64'd1, "core_reset before allcomplete is seen");
        @(posedge clk_74a);
        dataslot_allcomplete <= 1'b0;
        @(negedge clk_74a);
        compare_value(64'(core_reset), 64'd0, "core_reset after allcomplete");
    endtask

    task automatic run_download(input title_id_t id, input logic [7:0] r0, r1, r2);
        region_t      exp_region;
        bridge_word_t junk;
        bridge_word_t rd;
        junk = $urandom;
        exp_region = expected_region(r0, r1, r2);
        open_download();
        write_bus(rom_word({16'h0, 10'($urandom_range(129, 1023)), 2'b00}), $urandom);
        write_bus(rom_word(HDR_ID_BASE), {junk[31:8], id[63:56]});
        write_bus(rom_word(HDR_ID_BASE + 28'h4), id[55:24]);
        write_bus(rom_word(HDR_ID_BASE + 28'h8), {id[23:0], junk[7:0]});
        write_bus(rom_word(HDR_ID_DONE), junk);
        compare_value(64'(quirks), 64'(expected_quirks(id)), $sformatf("quirks of %s", id));
        write_bus(rom_word(HDR_REGION), {r0, r1, r2, junk[15:8]});
        compare_value(64'(core_reset), 64'd0, "core_reset before HDR_READY");
        write_bus(rom_word(HDR_READY), junk);
        compare_value(64'(region), 64'(exp_region), $sformatf("region of %h", {r0, r1, r2}));
        compare_value(64'(core_reset), 64'd1, "core_reset during region hold");
        read_bus(ADDR_REGION, rd);
        compare_value(64'(rd), 64'(exp_region), "region readback");
        read_bus(map_addrs[$urandom_range(0, 12)], rd);
        compare_value(64'(rd), 64'd0, "readback of a non-region address");
        finish_download();
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (core_reset && cycles < DELAY_TIMEOUT) begin
            @(negedge clk_74a);
            cycles++;
        end
        if (core_reset) begin
            errors++;
            $display("timeout: core_reset still high %0d cycles after the menu closed", cycles);
        end
    endtask

    initial begin
        bridge_word_t addr;
        bridge_word_t data;
        title_id_t    id;
        errors = 0;
        checks = 0;
        void'($urandom(32'hf95c));
        pll_core_locked       = 1'b0;
        bridge_addr           = '0;
        bridge_wr             = 1'b0;
        bridge_wr_data        = '0;
        bridge_rd             = 1'b0;
        osnotify_inmenu       = 1'b0;
        dataslot_requestwrite = 1'b0;
        dataslot_allcomplete  = 1'b0;
        keys                  = '0;
        exp_settings          = reset_settings();
        repeat (10) @(posedge clk_74a);
        pll_core_locked <= 1'b1;
        @(negedge clk_74a);
        compare_value(64'(settings), 64'(exp_settings), "settings after reset");
        compare_value(64'(core_reset), 64'd0, "core_reset after reset");
        compare_value(64'(pause), 64'd0, "pause after reset");
        compare_value(64'(quirks), 64'd0, "quirks after reset");
        compare_value(64'(region), 64'(REGION_JP), "region after reset");

        ////////////////////////////// settings writes
        for (int n = 0; n < SETTINGS_WRITES; n++) begin
            if ($urandom_range(0, 3) == 0)
                addr = {4'h0, 28'($urandom)}; // mostly unmapped
            else
                addr = map_addrs[$urandom_range(0, 13)];
            data = $urandom;
            if (addr == ADDR_RESET_DELAY)
                data = '0; // delay counter stays idle
            write_setting(addr, data);
            compare_value(64'(core_reset), 64'd0, "core_reset during settings writes");
        end

        ////////////////////////////// pads
        for (int n = 0; n < KEY_ROUNDS; n++) begin
            if (n % 10 == 0)
                write_setting(ADDR_M30, {31'd0, ~exp_settings.m30_map});
            @(posedge clk_74a);
            for (int i = 0; i < NUM_PADS; i++)
                keys[i] <= pocket_keys_t'(16'($urandom));
            @(posedge clk_74a);
            @(negedge clk_74a);
            check_pads();
        end

        ////////////////////////////// ROM downloads
        for (int n = 0; n < DOWNLOADS; n++) begin
            if ($urandom_range(0, 1) == 1)
                id = titles[$urandom_range(0, 8)];
            else
                id = {$urandom, $urandom};
            run_download(id, random_region_byte(), random_region_byte(), random_region_byte());
        end

        ////////////////////////////// reset delay and pause
        write_setting(ADDR_MENU_PAUSE, 32'd1);
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b1;
        write_setting(ADDR_RESET_DELAY, $urandom | 32'd1);
        repeat (50) begin
            @(negedge clk_74a);
            compare_value(64'(core_reset), 64'd1, "core_reset while in menu");
            compare_value(64'(pause), 64'd1, "pause while in menu");
        end
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b0;
        @(negedge clk_74a);
        wait_reset_release();
        compare_value(64'(pause), 64'd0, "pause after menu closed");
        write_setting(ADDR_MENU_PAUSE, 32'd0);
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b1;
        @(negedge clk_74a);
        @(negedge clk_74a);
        compare_value(64'(pause), 64'd0, "pause with menu_pause off");
        @(posedge clk_74a);
        osnotify_inmenu <= 1'b0;

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+tests
hdl/core_cfg_pkg.sv
hdl/cart_pkg.sv
hdl/core_settings.sv
hdl/cart_header_parser.sv
hdl/pad_mapper.sv
hdl/core_top.sv
tests/tb_core_top.sv

/* run.sh */
#!/usr/bin/env bash
# build tb_core_top with Verilator and run it, success only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_core_top \
    -o tb_core_top \
    && ./obj_dir/tb_core_top | tee /dev/stderr | grep -qx "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
